// ==== backend_tests.txt ====
# I op rd rs1 rs2 use_imm imm pc, op as coded in backend_pkg, imm and pc in hex
# C rd data, commit expected in order; R target, redirect expected in order
# ALU ops with register and immediate operands
I 0 1 0 0 1 00000015 00000000
C 1 00000015
I 0 2 0 0 1 fffffff9 00000004
C 2 fffffff9
I 0 3 1 2 0 00000000 00000008
C 3 0000000e
I 1 4 1 2 0 00000000 0000000c
C 4 0000001c
I 2 5 1 0 1 0000000f 00000010
C 5 00000005
I 3 6 1 2 0 00000000 00000014
C 6 fffffffd
I 4 7 2 0 1 000000ff 00000018
C 7 ffffff06
I 5 8 2 1 0 00000000 0000001c
C 8 00000001
I 6 9 2 1 0 00000000 00000020
C 9 00000000
I 5 10 1 0 1 fffffff0 00000024
C 10 00000000
I 6 11 1 0 1 00000100 00000028
C 11 00000001
# Dependent chain through EX1 and EX2
I 0 12 3 0 1 00000001 0000002c
C 12 0000000f
I 0 12 12 12 0 00000000 00000030
C 12 0000001e
I 1 13 12 3 0 00000000 00000034
C 13 00000010
I 4 14 13 12 0 00000000 00000038
C 14 0000000e
# Multiply with a dependent add, then two multiplies around an add
I 7 15 1 4 0 00000000 0000003c
C 15 0000024c
I 0 16 15 0 1 00000003 00000040
C 16 0000024f
I 7 17 2 1 0 00000000 00000044
C 17 ffffff6d
I 0 18 1 0 1 00000100 00000048
C 18 00000115
I 7 19 4 4 0 00000000 0000004c
C 19 00000310
# Branches and jump, wrong-path lines give no commit
I 8 20 3 14 0 00000010 00000050
C 20 00000054
R 00000060
I 0 21 0 0 1 00000077 00000054
I 1 21 1 2 0 00000000 00000058
I 9 22 1 1 0 00000040 00000060
C 22 00000064
I 11 23 0 0 0 0000001d 00000064
C 23 00000068
R 00000080
I 0 24 0 0 1 00000001 00000068
I 10 25 2 1 0 00000010 00000080
C 25 00000084
R 00000090
I 3 26 0 0 0 00000000 00000084
# Register x0 stays zero
I 0 0 1 0 1 00000001 00000090
C 0 00000016
I 0 26 0 0 1 00000005 00000094
C 26 00000005
I 3 27 0 1 0 00000000 00000098
C 27 00000015
I 1 28 1 0 0 00000000 0000009c
C 28 00000015

// ==== sources.f ====
backend_pkg.sv
reg_file.sv
operand_bypass.sv
alu_unit.sv
mul_unit.sv
issue_ctrl.sv
result_pipe.sv
exec_backend.sv
tb_exec_backend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_exec_backend &&
./obj_dir/Vtb_exec_backend | tee /dev/stderr | grep -qx "Regression passed" &&
echo "Simulation OK" ||
{ echo "Simulation FAILED"; exit 1; }

// ==== tb_exec_backend.sv ====
`timescale 1ns/1ps

module tb_exec_backend
    import backend_pkg::*;
();

    localparam int unsigned XLEN     = xlen_p;
    localparam word_t       RESET_PC = '0;

    logic         clk;
    logic         rst_n;
    logic         instr_valid;
    issue_instr_t instr;
    logic         instr_ready;
    logic         wb_valid;
    reg_idx_t     wb_rd;
    word_t        wb_data;
    logic         redir_valid;
    word_t        redir_pc;

    // Stimulus and expected responses in file order
    issue_instr_t instr_q[$];
    reg_idx_t     exp_rd_q[$];
    word_t        exp_data_q[$];
    word_t        exp_target_q[$];

    int commits_seen;
    int redirects_seen;
    int value_errs;
    int missing_errs;
    int extra_errs;
    int cycle_count;
    int cycle_limit;

    exec_backend #(.XLEN(XLEN), .RESET_PC(RESET_PC)) uut (
        .clk_i(clk), .rst_ni(rst_n),
        .instr_valid_i(instr_valid), .instr_i(instr), .instr_ready_o(instr_ready),
        .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .redirect_valid_o(redir_valid), .redirect_pc_o(redir_pc)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Tests file reader
    //////////////////////////////////////////////////

    task automatic load_tests(output bit ok);
        int           fd;
        int           code;
        int           op;
        int           rd;
        int           rs1;
        int           rs2;
        int           use_imm;
        word_t        imm;
        word_t        pc;
        word_t        value;
        logic [7:0]   kind;
        issue_instr_t ins;
        ok = 1'b1;
        fd = $fopen("backend_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open backend_tests.txt");
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": begin
                        // Comment runs to the end of the line
                        do begin
                            code = $fscanf(fd, "%c", kind);
                        end while (code == 1 && kind != 8'h0a);
                    end
                    "I": begin
                        code = $fscanf(fd, "%d %d %d %d %d %h %h",
                                       op, rd, rs1, rs2, use_imm, imm, pc);
                        ins.op      = alu_op_e'(op[3:0]);
                        ins.rd      = rd[4:0];
                        ins.rs1     = rs1[4:0];
                        ins.rs2     = rs2[4:0];
                        ins.use_imm = use_imm[0];
                        ins.imm     = imm;
                        ins.pc      = pc;
                        instr_q.push_back(ins);
                        if (code != 7) ok = 1'b0;
                    end
                    "C": begin
                        code = $fscanf(fd, "%d %h", rd, value);
                        exp_rd_q.push_back(rd[4:0]);
                        exp_data_q.push_back(value);
                        if (code != 2) ok = 1'b0;
                    end
                    "R": begin
                        code = $fscanf(fd, "%h", pc);
                        exp_target_q.push_back(pc);
                        if (code != 1) ok = 1'b0;
                    end
                    default: ok = 1'b0;
                endcase
            end
            $fclose(fd);
            if (!ok || instr_q.size() == 0) begin
                $display("backend_tests.txt holds a malformed line or no instructions");
                ok = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Driver and monitor
    //////////////////////////////////////////////////

    // Each instruction is held until the DUT takes it
    task automatic drive_all();
        foreach (instr_q[i]) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b1;
            instr       = instr_q[i];
            @(negedge clk);
            while (!instr_ready) @(negedge clk);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
    endtask

    task automatic check_commit();
        if (commits_seen >= exp_rd_q.size()) begin
            extra_errs++;
            $display("Unexpected commit of %h to x%0d at %0t, all expected commits were seen",
                     wb_data, wb_rd, $time);
        end else if (wb_rd != exp_rd_q[commits_seen] || wb_data != exp_data_q[commits_seen]) begin
            value_errs++;
            $display("** Error at %0t: commit %0d wrote x%0d = %h, expected x%0d = %h",
                     $time, commits_seen, wb_rd, wb_data,
                     exp_rd_q[commits_seen], exp_data_q[commits_seen]);
        end
        commits_seen++;
    endtask

    task automatic check_redirect();
        if (redirects_seen >= exp_target_q.size()) begin
            extra_errs++;
            $display("Unexpected redirect to %h at %0t", redir_pc, $time);
        end else if (redir_pc != exp_target_q[redirects_seen]) begin
            value_errs++;
            $display("** Error at %0t: redirect %0d went to %h, expected %h",
                     $time, redirects_seen, redir_pc, exp_target_q[redirects_seen]);
        end
        redirects_seen++;
    endtask

    task automatic report_error_totals();
        $display("Errors: %0d wrong values, %0d missing, %0d extra",
                 value_errs, missing_errs, extra_errs);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_valid) check_commit();
            if (redir_valid) check_redirect();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            if (commits_seen < exp_rd_q.size()) missing_errs += exp_rd_q.size() - commits_seen;
            $display("Timeout after %0d cycles with %0d of %0d commits seen",
                     cycle_count, commits_seen, exp_rd_q.size());
            report_error_totals();
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        bit ok;
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        cycle_limit = 0;
        load_tests(ok);
        if (!ok) begin
            $display("Run stopped because the tests file could not be read");
            $display("Regression failed");
            $finish;
        end else begin
            cycle_limit = instr_q.size() * (XLEN + 10);
            repeat (2) @(posedge clk);
            #1 rst_n = 1'b1;
            drive_all();
            while (commits_seen < exp_rd_q.size()) @(negedge clk);
            // Quiet period long enough for a stray multiply to show up
            repeat (XLEN + 4) @(negedge clk);
            if (redirects_seen < exp_target_q.size()) begin
                missing_errs += exp_target_q.size() - redirects_seen;
                $display("Only %0d of %0d expected redirects were seen",
                         redirects_seen, exp_target_q.size());
            end
            report_error_totals();
            if (value_errs + missing_errs + extra_errs == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

// ==== exec_backend.sv ====
`timescale 1ns/1ps

module exec_backend import backend_pkg::*; #(
    parameter int unsigned XLEN     = xlen_p,
    parameter word_t       RESET_PC = '0
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         instr_valid_i,
    input  issue_instr_t instr_i,
    output logic         instr_ready_o,
    output logic         wb_valid_o,
    output reg_idx_t     wb_rd_o,
    output word_t        wb_data_o,
    output logic         redirect_valid_o,
    output word_t        redirect_pc_o
);

    word_t      rf_a;
    word_t      rf_b;
    word_t      rs1;
    word_t      rs2;
    word_t      alu_result;
    word_t      target;
    word_t      mul_value;
    stage_fwd_t ex1_fwd;
    stage_fwd_t ex2_fwd;
    logic       data_hazard;
    logic       taken;
    logic       issue;
    logic       mul_start;
    logic       mul_ready;
    logic       mul_valid;
    logic       ex1_ready;

    // Register read uses the incoming instruction's sources
    reg_file #(.XLEN(XLEN)) u_reg_file (
        .clk_i, .rst_ni,
        .ra_i(instr_i.rs1), .rb_i(instr_i.rs2), .ra_data_o(rf_a), .rb_data_o(rf_b),
        .we_i(wb_valid_o), .wa_i(wb_rd_o), .wd_i(wb_data_o)
    );

    operand_bypass #(.XLEN(XLEN)) u_bypass (
        .instr_i, .rf_a_i(rf_a), .rf_b_i(rf_b), .ex1_fwd_i(ex1_fwd), .ex2_fwd_i(ex2_fwd),
        .rs1_o(rs1), .rs2_o(rs2), .data_hazard_o(data_hazard)
    );

    alu_unit #(.XLEN(XLEN)) u_alu (
        .instr_i, .rs1_i(rs1), .rs2_i(rs2),
        .result_o(alu_result), .taken_o(taken), .target_o(target)
    );

    issue_ctrl #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_issue_ctrl (
        .clk_i, .rst_ni, .instr_valid_i, .instr_i,
        .data_hazard_i(data_hazard), .mul_ready_i(mul_ready), .ex1_ready_i(ex1_ready),
        .taken_i(taken), .target_i(target),
        .instr_ready_o, .issue_o(issue), .mul_start_o(mul_start),
        .redirect_valid_o, .redirect_pc_o
    );

    mul_unit #(.XLEN(XLEN)) u_mul (
        .clk_i, .rst_ni, .start_i(mul_start), .a_i(rs1), .b_i(rs2),
        .ready_o(mul_ready), .valid_o(mul_valid), .value_o(mul_value)
    );

    result_pipe #(.XLEN(XLEN)) u_result_pipe (
        .clk_i, .rst_ni, .issue_i(issue), .instr_i, .alu_result_i(alu_result),
        .mul_valid_i(mul_valid), .mul_value_i(mul_value),
        .ex1_ready_o(ex1_ready), .ex1_fwd_o(ex1_fwd), .ex2_fwd_o(ex2_fwd),
        .wb_valid_o, .wb_rd_o, .wb_data_o
    );

endmodule

// ==== result_pipe.sv ====
`timescale 1ns/1ps

module result_pipe import backend_pkg::*; #(
    parameter int unsigned XLEN = xlen_p
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         issue_i,
    input  issue_instr_t instr_i,
    input  word_t        alu_result_i,
    input  logic         mul_valid_i,
    input  word_t        mul_value_i,
    output logic         ex1_ready_o,
    output stage_fwd_t   ex1_fwd_o,
    output stage_fwd_t   ex2_fwd_o,
    output logic         wb_valid_o,
    output reg_idx_t     wb_rd_o,
    output word_t        wb_data_o
);

    logic            ex1_pending_q;
    logic            ex1_pending_d;
    reg_idx_t        ex1_rd_q;
    reg_idx_t        ex1_rd_d;
    func_unit_e      ex1_sel_q;
    func_unit_e      ex1_sel_d;
    logic [XLEN-1:0] ex1_alu_q;
    logic            ex1_data_valid;
    logic [XLEN-1:0] ex1_data;

    logic            ex2_pending_q;
    logic            ex2_pending_d;
    reg_idx_t        ex2_rd_q;
    reg_idx_t        ex2_rd_d;
    func_unit_e      ex2_sel_q;
    func_unit_e      ex2_sel_d;
    logic [XLEN-1:0] ex2_alu_q;
    logic            ex2_data_valid;
    logic [XLEN-1:0] ex2_data;

    logic            ex2_ready;
    logic            ex1_move;

    //////////////////////////////////////////////////
    // Stage data select
    //////////////////////////////////////////////////

    // While EX2 waits on the multiplier, its valid belongs to EX2
    assign ex1_data_valid = ex1_sel_q == FU_ALU || (mul_valid_i && ex2_sel_q != FU_MUL);
    assign ex1_data       = ex1_sel_q == FU_ALU ? ex1_alu_q : mul_value_i;

    assign ex2_data_valid = ex2_sel_q == FU_ALU || mul_valid_i;
    assign ex2_data       = ex2_sel_q == FU_ALU ? ex2_alu_q : mul_value_i;

    assign ex2_ready   = !ex2_pending_q || ex2_data_valid;
    assign ex1_move    = ex1_pending_q && ex2_ready;
    assign ex1_ready_o = ex2_ready || !ex1_pending_q;

    //////////////////////////////////////////////////
    // Stage control
    //////////////////////////////////////////////////

    always_comb begin
        ex1_pending_d = ex1_pending_q;
        ex1_rd_d      = ex1_rd_q;
        ex1_sel_d     = ex1_sel_q;
        ex2_pending_d = ex2_pending_q;
        ex2_rd_d      = ex2_rd_q;
        ex2_sel_d     = ex2_sel_q;

        // Late result is parked in the ALU register
        if (ex1_data_valid) ex1_sel_d = FU_ALU;
        if (ex2_ready) begin
            ex1_pending_d = 1'b0;
            ex1_sel_d     = FU_ALU;
        end
        if (issue_i) begin
            ex1_pending_d = 1'b1;
            ex1_rd_d      = instr_i.rd;
            ex1_sel_d     = instr_i.op == OP_MUL ? FU_MUL : FU_ALU;
        end

        // Commit frees EX2
        if (ex2_data_valid) begin
            ex2_pending_d = 1'b0;
            ex2_sel_d     = FU_ALU;
        end
        if (ex1_move) begin
            ex2_pending_d = 1'b1;
            ex2_rd_d      = ex1_rd_q;
            ex2_sel_d     = ex1_data_valid ? FU_ALU : ex1_sel_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_pending_q <= 1'b0;
            ex1_rd_q      <= '0;
            ex1_sel_q     <= FU_ALU;
            ex2_pending_q <= 1'b0;
            ex2_rd_q      <= '0;
            ex2_sel_q     <= FU_ALU;
        end else begin
            ex1_pending_q <= ex1_pending_d;
            ex1_rd_q      <= ex1_rd_d;
            ex1_sel_q     <= ex1_sel_d;
            ex2_pending_q <= ex2_pending_d;
            ex2_rd_q      <= ex2_rd_d;
            ex2_sel_q     <= ex2_sel_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            ex1_alu_q <= alu_result_i;
        end else if (ex1_data_valid) begin
            ex1_alu_q <= ex1_data;
        end
        if (ex1_move) ex2_alu_q <= ex1_data;
    end

    assign ex1_fwd_o = '{pending: ex1_pending_q, rd: ex1_rd_q,
                         data_valid: ex1_data_valid, data: ex1_data};
    assign ex2_fwd_o = '{pending: ex2_pending_q, rd: ex2_rd_q,
                         data_valid: ex2_data_valid, data: ex2_data};

    // Retire from EX2 in issue order
    assign wb_valid_o = ex2_pending_q && ex2_data_valid;
    assign wb_rd_o    = ex2_rd_q;
    assign wb_data_o  = ex2_data;

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl import backend_pkg::*; #(
    parameter int unsigned XLEN     = xlen_p,
    parameter word_t       RESET_PC = '0
) (
    input  logic         clk_i,
    input  logic         rst_ni,

    // Decoded instruction in
    input  logic         instr_valid_i,
    input  issue_instr_t instr_i,

    // Hazard sources
    input  logic         data_hazard_i,
    input  logic         mul_ready_i,
    input  logic         ex1_ready_i,

    // Branch resolution from the ALU
    input  logic         taken_i,
    input  word_t        target_i,

    output logic         instr_ready_o,
    output logic         issue_o,
    output logic         mul_start_o,
    output logic         redirect_valid_o,
    output word_t        redirect_pc_o
);

    logic            struct_hazard;
    logic            control_hazard;
    logic            accept;
    logic [XLEN-1:0] next_pc;

    word_t           expected_pc_q;
    word_t           expected_pc_d;
    logic            mispredict_q;
    logic            mispredict_d;

    //////////////////////////////////////////////////
    // Hazard detection
    //////////////////////////////////////////////////

    // EX1 full, or a multiply while the multiplier is still busy
    always_comb begin
        struct_hazard = !ex1_ready_i;
        if (instr_i.op == OP_MUL && !mul_ready_i) begin
            struct_hazard = 1'b1;
        end
    end

    // Anything off the expected path is dropped
    assign control_hazard = instr_i.pc != expected_pc_q;

    //////////////////////////////////////////////////
    // Issue decision
    //////////////////////////////////////////////////

    assign issue_o = instr_valid_i && !data_hazard_i && !struct_hazard && !control_hazard;

    // Wrong-path instructions are always taken and thrown away
    assign instr_ready_o = (!data_hazard_i && !struct_hazard) || control_hazard;

    assign mul_start_o = issue_o && instr_i.op == OP_MUL;

    assign accept = instr_valid_i && instr_ready_o;

    //////////////////////////////////////////////////
    // Expected PC and mispredict tracking
    //////////////////////////////////////////////////

    assign next_pc = instr_i.pc + XLEN'(4);

    always_comb begin
        expected_pc_d = expected_pc_q;
        mispredict_d  = mispredict_q;

        // Cleared by an issue, set by the first discarded instruction
        if (accept) begin
            mispredict_d = control_hazard;
        end

        if (issue_o) begin
            expected_pc_d = taken_i ? target_i : next_pc;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            expected_pc_q <= RESET_PC;
            mispredict_q  <= 1'b0;
        end else begin
            expected_pc_q <= expected_pc_d;
            mispredict_q  <= mispredict_d;
        end
    end

    // One pulse per wrong path, pointing at where fetch should go
    assign redirect_valid_o = instr_valid_i && control_hazard && !mispredict_q;
    assign redirect_pc_o    = expected_pc_q;

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit import backend_pkg::*; #(
    parameter int unsigned XLEN = xlen_p
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  start_i,
    input  word_t a_i,
    input  word_t b_i,
    output logic  ready_o,
    output logic  valid_o,
    output word_t value_o
);

    localparam int unsigned CNT_W = $clog2(XLEN);

    logic             busy_q;
    logic             valid_q;
    logic [CNT_W-1:0] count_q;

    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [XLEN-1:0]  acc_q;
    logic [XLEN-1:0]  acc_next;

    // One partial product per cycle, low multiplier bit first
    assign acc_next = mplier_q[0] ? acc_q + mcand_q : acc_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            count_q <= '0;
        end else if (start_i) begin
            busy_q  <= 1'b1;
            valid_q <= 1'b0;
            count_q <= '0;
        end else if (busy_q) begin
            count_q <= count_q + CNT_W'(1);
            if (count_q == CNT_W'(XLEN - 1)) begin
                busy_q  <= 1'b0;
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if (busy_q) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign ready_o = !busy_q;
    // Result stays visible until the next start
    assign valid_o = valid_q;
    assign value_o = acc_q;

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit import backend_pkg::*; #(
    parameter int unsigned XLEN = xlen_p
) (
    input  issue_instr_t instr_i,
    input  word_t        rs1_i,
    input  word_t        rs2_i,
    output word_t        result_o,
    output logic         taken_o,
    output word_t        target_o
);

    logic            is_branch;
    word_t           operand_b;
    logic [XLEN-1:0] add_a;
    logic [XLEN-1:0] add_b;
    logic [XLEN-1:0] sum;
    logic [XLEN:0]   diff_ext;
    logic [XLEN-1:0] diff;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic [XLEN-1:0] link;

    assign is_branch = instr_i.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_JAL};
    assign operand_b = instr_i.use_imm ? instr_i.imm : rs2_i;

    // Shared adder, ADD or pc+imm for control transfers
    assign add_a = is_branch ? instr_i.pc : rs1_i;
    assign add_b = is_branch ? instr_i.imm : operand_b;
    assign sum   = add_a + add_b;

    // Subtractor with borrow out for the unsigned compare
    assign diff_ext = {1'b0, rs1_i} - {1'b0, operand_b};
    assign diff     = diff_ext[XLEN-1:0];

    assign eq  = diff == '0;
    assign ltu = diff_ext[XLEN];
    // Signs differ means the negative one is smaller
    assign lt  = (rs1_i[XLEN-1] != operand_b[XLEN-1]) ? rs1_i[XLEN-1] : diff[XLEN-1];

    assign link     = instr_i.pc + XLEN'(4);
    assign target_o = {sum[XLEN-1:1], 1'b0};

    always_comb begin
        case (instr_i.op)
            OP_BEQ:  taken_o = eq;
            OP_BNE:  taken_o = !eq;
            OP_BLT:  taken_o = lt;
            OP_JAL:  taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    always_comb begin
        case (instr_i.op)
            OP_ADD:  result_o = sum;
            OP_SUB:  result_o = diff;
            OP_AND:  result_o = rs1_i & operand_b;
            OP_OR:   result_o = rs1_i | operand_b;
            OP_XOR:  result_o = rs1_i ^ operand_b;
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, ltu};
            OP_BEQ, OP_BNE, OP_BLT, OP_JAL: result_o = link;
            // Multiply comes from its own unit
            default: result_o = '0;
        endcase
    end

endmodule

// ==== operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass import backend_pkg::*; #(
    parameter int unsigned XLEN = xlen_p
) (
    input  issue_instr_t instr_i,
    input  word_t        rf_a_i,
    input  word_t        rf_b_i,
    input  stage_fwd_t   ex1_fwd_i,
    input  stage_fwd_t   ex2_fwd_i,
    output word_t        rs1_o,
    output word_t        rs2_o,
    output logic         data_hazard_o
);

    // Top bit flags a hazard, the rest is the operand value
    logic [XLEN:0] src_a;
    logic [XLEN:0] src_b;

    function automatic logic [XLEN:0] pick_src(reg_idx_t idx, word_t rf_val,
                                               stage_fwd_t ex1, stage_fwd_t ex2);
        logic [XLEN:0] res;
        res = {1'b0, rf_val};
        if (idx != '0 && ex2.pending && ex2.rd == idx) begin
            res = ex2.data_valid ? {1'b0, ex2.data} : {1'b1, rf_val};
        end
        // EX1 holds the younger write to the same register
        if (idx != '0 && ex1.pending && ex1.rd == idx) begin
            res = ex1.data_valid ? {1'b0, ex1.data} : {1'b1, rf_val};
        end
        return res;
    endfunction

    assign src_a = pick_src(instr_i.rs1, rf_a_i, ex1_fwd_i, ex2_fwd_i);
    assign src_b = pick_src(instr_i.rs2, rf_b_i, ex1_fwd_i, ex2_fwd_i);

    assign rs1_o = src_a[XLEN-1:0];
    assign rs2_o = src_b[XLEN-1:0];

    assign data_hazard_o = src_a[XLEN] || src_b[XLEN];

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import backend_pkg::*; #(
    parameter int unsigned XLEN = xlen_p
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  reg_idx_t ra_i,
    input  reg_idx_t rb_i,
    output word_t    ra_data_o,
    output word_t    rb_data_o,
    input  logic     we_i,
    input  reg_idx_t wa_i,
    input  word_t    wd_i
);

    logic [XLEN-1:0] regs_q [32];

    // x0 is never written, so it reads back zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs_q[wa_i] <= wd_i;
        end
    end

    assign ra_data_o = regs_q[ra_i];
    assign rb_data_o = regs_q[rb_i];

endmodule

// ==== backend_pkg.sv ====
package backend_pkg;

    // Default data path width
    localparam int unsigned xlen_p = 32;

    typedef logic [4:0]        reg_idx_t;
    typedef logic [xlen_p-1:0] word_t;

    //////////////////////////////////////////////////
    // Operation and unit encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLTU = 4'd6,
        OP_MUL  = 4'd7,
        OP_BEQ  = 4'd8,
        OP_BNE  = 4'd9,
        OP_BLT  = 4'd10,
        OP_JAL  = 4'd11
    } alu_op_e;

    // Where a result stage takes its value from
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } func_unit_e;

    //////////////////////////////////////////////////
    // Structs passed between modules
    //////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        word_t    imm;
        word_t    pc;
    } issue_instr_t;

    // Published by each result stage for the bypass network
    typedef struct packed {
        logic     pending;
        reg_idx_t rd;
        logic     data_valid;
        word_t    data;
    } stage_fwd_t;

endpackage
